//--- obj_render.f
src/obj_pkg.sv
src/obj_attr_fetch.sv
src/obj_sequencer.sv
src/obj_pixel_addr.sv
src/obj_pixel_unpack.sv
src/obj_line_buffer.sv
src/obj_render_top.sv
verification/obj_mem_model.sv
verification/obj_render_tb.sv

//--- Makefile
.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal \
		--top-module obj_render_tb -f obj_render.f \
		-Mdir obj_dir -o obj_render_sim

run: compile
	./obj_dir/obj_render_sim > run.log 2>&1 || true
	cat run.log
	grep -q "^TEST OK$$" run.log

clean:
	rm -rf obj_dir run.log

//--- verification/obj_render_tb.sv
`timescale 1ns/1ps
`default_nettype none

module obj_render_tb import obj_pkg::*; ();

    logic                   clock;
    logic                   reset;
    logic                   line_start;
    logic [7:0]             vcount;
    logic [7:0]             hcount;
    logic [15:0]            mosaic_reg;
    logic                   obj_1d_map;
    logic [31:0]            oam_data;
    logic [15:0]            vram_data;
    logic [OAM_ADDR_W-1:0]  oam_addr;
    logic [VRAM_ADDR_W-1:0] vram_addr;
    obj_pixel_t             obj_packet;
    logic                   lines_on;
    int                     errors;
    int                     seed;
    logic [31:0]            oam_sh [256];
    logic [15:0]            vram_sh [16384];

    obj_render_top uut (
        .clock, .reset, .line_start, .vcount, .hcount, .mosaic_reg, .obj_1d_map,
        .oam_data, .vram_data, .oam_addr, .vram_addr, .obj_packet
    );

    obj_mem_model u_mem (.clock, .oam_addr, .oam_data, .vram_addr, .vram_data);

    initial begin
        clock = 1'b0;
        forever #2 clock = ~clock;
    end

    // display timing, one line every 1232 cycles.
    initial begin : line_timer
        int cnt;
        cnt        = 0;
        line_start = 1'b0;
        forever begin
            @(posedge clock);
            #1;
            if (lines_on) begin
                line_start = (cnt == 0);
                cnt        = (cnt == 1231) ? 0 : cnt + 1;
            end else begin
                line_start = 1'b0;
            end
        end
    end

    task automatic put_oam(input int addr, input logic [31:0] value);
        oam_sh[addr] = value;
        u_mem.write_oam(addr[7:0], value);
    endtask

    task automatic put_vram(input int addr, input logic [15:0] value);
        vram_sh[addr] = value;
        u_mem.write_vram(addr[13:0], value);
    endtask

    task automatic clear_oam();
        for (int n = 0; n < NUM_OBJECTS; n++) begin
            put_oam(2 * n, 32'h0000_0c00);
            put_oam(2 * n + 1, 32'h0);
        end
    endtask

    task automatic set_obj(input int n, input logic [7:0] y, input logic [8:0] x,
                           input logic [1:0] shape, input logic [1:0] size,
                           input logic [1:0] mode, input logic bpp8, input logic mos,
                           input logic hf, input logic vf, input logic dbl,
                           input logic [9:0] tile, input logic [1:0] prio,
                           input logic [3:0] pal);
        logic [15:0] a0;
        logic [15:0] a1;
        a0 = {shape, bpp8, mos, mode, dbl, 1'b0, y};
        a1 = {size, vf, hf, 3'b000, x};
        put_oam(2 * n, {a1, a0});
        put_oam(2 * n + 1, {16'h0, pal, prio, tile});
    endtask

    function automatic void obj_size(input int shape, input int size, output int w,
                                     output int h);
        int sq[4];
        int wide_w[4];
        int wide_h[4];
        sq     = '{8, 16, 32, 64};
        wide_w = '{16, 32, 32, 64};
        wide_h = '{8, 8, 16, 32};
        w = 8;
        h = 8;
        if (shape == 0) begin
            w = sq[size];
            h = sq[size];
        end else if (shape == 1) begin
            w = wide_w[size];
            h = wide_h[size];
        end else if (shape == 2) begin
            w = wide_h[size];
            h = wide_w[size];
        end
    endfunction

    // walks OAM in index order, the first opaque pixel on the column wins.
    function automatic obj_pixel_t expect_pixel(input int row, input int col);
        obj_pixel_t  p;
        logic [15:0] a0;
        logic [15:0] a1;
        logic [15:0] a2;
        logic [15:0] hw;
        logic [7:0]  bytev;
        logic [3:0]  nib;
        int w, h, dy, dx, px, py, tile, stride, bytea, mw, mh;
        p  = '0;
        mw = mosaic_reg[11:8] + 1;
        mh = mosaic_reg[15:12] + 1;
        for (int n = 0; n < NUM_OBJECTS; n++) begin
            a0 = oam_sh[2 * n][15:0];
            a1 = oam_sh[2 * n][31:16];
            a2 = oam_sh[2 * n + 1][15:0];
            obj_size(a0[15:14], a1[15:14], w, h);
            dy = (row - a0[7:0]) & 255;
            dx = (col - a1[8:0]) & 511;
            if (a0[9] || a0[11:10] >= 2 || dy >= h || dx >= w) continue;
            if (a0[12]) begin
                dx = dx - dx % mw;
                dy = dy - dy % mh;
            end
            px     = a1[12] ? w - 1 - dx : dx;
            py     = a1[13] ? h - 1 - dy : dy;
            stride = obj_1d_map ? (w / 8) * (a0[13] ? 2 : 1) : 32;
            tile   = (a2[9:0] + (py / 8) * stride + (px / 8) * (a0[13] ? 2 : 1)) % 1024;
            bytea  = tile * 32 + (a0[13] ? (py % 8) * 8 + px % 8 : (py % 8) * 4 + (px % 8) / 2);
            hw     = vram_sh[(bytea / 2) % 16384];
            bytev  = (bytea % 2) ? hw[15:8] : hw[7:0];
            nib    = (px % 2) ? bytev[7:4] : bytev[3:0];
            if (a0[13] ? bytev == 8'd0 : nib == 4'd0) continue;  // transparent.
            p.present = 1'b1;
            p.prio    = a2[11:10];
            p.semi    = (a0[11:10] == 2'd1);
            p.bpp8    = a0[13];
            p.index   = a0[13] ? bytev : {a2[15:12], nib};
            return p;
        end
        return p;
    endfunction

    task automatic wait_line_start();
        int n;
        n = 0;
        @(posedge clock);
        while (!line_start && n < 2500) begin
            n++;
            @(posedge clock);
        end
        if (line_start) begin
            #1;
        end else begin
            $display("timeout: no line_start pulse within 2500 cycles");
            $display("TEST FAILED");
            $finish;
        end
    endtask

    // reads the front bank column by column, one cycle of latency per read.
    task automatic sweep(input string name, input int row, input logic blank);
        obj_pixel_t            exp;
        logic [OAM_ADDR_W-1:0] exp_oam;
        for (int c = 0; c < LINE_WIDTH; c++) begin
            hcount = c[7:0];
            @(posedge clock);
            #1;
            exp = blank ? '0 : expect_pixel(row, c);
            assert (obj_packet === exp) else begin
                errors++;
                $display("Fail %s col %0d: expected %h, actual %h", name, c, exp, obj_packet);
            end
            // one cycle into a pass the fetch reads the second word of object 0.
            if (blank || c == 0) begin
                exp_oam = blank ? 8'd0 : 8'd1;
                assert (oam_addr === exp_oam && vram_addr === '0) else begin
                    errors++;
                    $display("Fail %s col %0d: expected oam/vram address %h/0, actual %h/%h",
                             name, c, exp_oam, oam_addr, vram_addr);
                end
            end
        end
    endtask

    task automatic start_pass(input int row);
        wait_line_start();
        vcount = 8'(row - 1);
    endtask

    task automatic check_line(input string name, input int row);
        wait_line_start();
        vcount = 8'(row);  // the next pass renders another row while this one is read.
        sweep(name, row, 1'b0);
    endtask

    initial begin : main
        int w;
        int h;
        seed       = 85329;
        errors     = 0;
        lines_on   = 1'b0;
        reset      = 1'b1;
        vcount     = '0;
        hcount     = '0;
        mosaic_reg = '0;
        obj_1d_map = 1'b1;
        for (int a = 0; a < 16384; a++) put_vram(a, 16'($random(seed)));
        clear_oam();
        repeat (4) @(posedge clock);
        #1;
        reset = 1'b0;
        sweep("reset", 0, 1'b1);
        lines_on = 1'b1;

        start_pass(53);
        clear_oam();
        set_obj(0, 50, 100, 0, 0, 1, 0, 0, 0, 0, 0, 4, 2, 5);
        check_line("basic_8x8", 53);

        start_pass(58);
        clear_oam();
        set_obj(0, 55, 10, 0, 1, 0, 0, 0, 0, 0, 0, 8, 1, 2);
        set_obj(1, 55, 40, 0, 1, 0, 0, 0, 1, 0, 0, 8, 1, 2);
        set_obj(2, 55, 70, 0, 1, 0, 0, 0, 0, 1, 0, 8, 1, 2);
        set_obj(3, 55, 100, 0, 1, 0, 0, 0, 1, 1, 0, 8, 1, 2);
        check_line("flips", 58);

        for (int m = 1; m >= 0; m--) begin
            start_pass(70);
            clear_oam();
            obj_1d_map = m[0];
            set_obj(0, 62, 30, 1, 2, 0, 1, 0, 0, 0, 0, 32, 0, 0);
            set_obj(1, 50, 120, 2, 1, 0, 1, 0, 1, 0, 0, 64, 3, 0);
            check_line(m ? "map_1d_8bpp" : "map_2d_8bpp", 70);
        end
        obj_1d_map = 1'b1;

        start_pass(91);
        clear_oam();
        set_obj(0, 88, 20, 0, 0, 0, 0, 0, 0, 0, 0, 100, 0, 1);
        set_obj(1, 80, 16, 0, 1, 0, 0, 0, 0, 0, 0, 120, 3, 7);
        put_vram(100 * 16 + 6, 16'h0f00);  // only pixel 2 of the row is opaque.
        put_vram(100 * 16 + 7, 16'h0000);
        check_line("overlap", 91);

        start_pass(130);
        clear_oam();
        set_obj(0, 128, 508, 1, 0, 0, 0, 0, 0, 0, 0, 200, 1, 3);
        set_obj(1, 125, 232, 0, 1, 0, 0, 0, 0, 0, 0, 210, 1, 4);
        set_obj(2, 128, 100, 0, 0, 2, 0, 0, 0, 0, 0, 220, 0, 1);
        set_obj(3, 128, 110, 0, 0, 0, 0, 0, 0, 0, 1, 220, 0, 1);
        set_obj(4, 128, 120, 0, 0, 3, 0, 0, 0, 0, 0, 220, 0, 1);
        set_obj(5, 140, 130, 0, 0, 0, 0, 0, 0, 0, 0, 220, 0, 1);
        check_line("wrap_clip_hidden", 130);

        start_pass(3);
        clear_oam();
        set_obj(0, 250, 60, 0, 1, 0, 0, 0, 0, 0, 0, 240, 2, 6);
        check_line("wrap_vertical", 3);

        mosaic_reg = 16'h2300;
        for (int r = 105; r <= 107; r += 2) begin
            start_pass(r);
            clear_oam();
            set_obj(0, 100, 50, 0, 2, 0, 0, 1, 0, 0, 0, 300, 0, 8);
            set_obj(1, 100, 150, 0, 2, 0, 1, 1, 1, 0, 0, 300, 0, 0);
            check_line("mosaic", r);
        end
        mosaic_reg = '0;

        for (int s = 0; s < 3; s++) begin
            for (int z = 0; z < 4; z++) begin
                obj_size(s, z, w, h);
                start_pass(20 + h - 1);
                clear_oam();
                set_obj(0, 20, 40, s[1:0], z[1:0], 0, 0, 0, 0, z[0], 0, 400, 1, 9);
                check_line($sformatf("shape%0d_size%0d", s, z), 20 + h - 1);
            end
        end

        $display("checks done, errors: %0d", errors);
        if (errors == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- verification/obj_mem_model.sv
`timescale 1ns/1ps
`default_nettype none

module obj_mem_model import obj_pkg::*; (
    input  logic                   clock,
    input  logic [OAM_ADDR_W-1:0]  oam_addr,
    output logic [31:0]            oam_data,
    input  logic [VRAM_ADDR_W-1:0] vram_addr,
    output logic [15:0]            vram_data
);

    logic [31:0] oam [2**OAM_ADDR_W];
    logic [15:0] vram [2**VRAM_ADDR_W];

    // both memories answer one cycle after the address, like the real OAM and VRAM.
    always @(posedge clock) begin
        oam_data  <= oam[oam_addr];
        vram_data <= vram[vram_addr];
    end

    task automatic write_oam(input logic [OAM_ADDR_W-1:0] addr, input logic [31:0] value);
        oam[addr] = value;
    endtask

    task automatic write_vram(input logic [VRAM_ADDR_W-1:0] addr, input logic [15:0] value);
        vram[addr] = value;
    endtask

    initial begin
        oam_data  = '0;
        vram_data = '0;
    end

endmodule

`default_nettype wire

//--- src/obj_render_top.sv
`timescale 1ns/1ps
`default_nettype none

module obj_render_top import obj_pkg::*; (
    input  logic                   clock,
    input  logic                   reset,
    input  logic                   line_start,
    input  logic [7:0]             vcount,
    input  logic [7:0]             hcount,
    input  logic [15:0]            mosaic_reg,
    input  logic                   obj_1d_map,
    input  logic [31:0]            oam_data,
    input  logic [15:0]            vram_data,
    output logic [OAM_ADDR_W-1:0]  oam_addr,
    output logic [VRAM_ADDR_W-1:0] vram_addr,
    output obj_pixel_t             obj_packet
);

    logic [7:0] render_row;
    logic       fetch_start;
    logic [6:0] obj_index;
    obj_attr_t  attr;
    logic       attr_valid;
    logic       covered;
    logic [6:0] col_offset;
    logic       req_valid;
    obj_req_t   req;
    logic       req_in_line;
    obj_req_t   req_q;
    logic       req_live_q;
    obj_pixel_t pixel;
    logic       write;

    assign render_row = vcount + 8'd1;  // rows are built one line ahead of display.

    obj_attr_fetch u_attr_fetch (
        .clock, .reset, .fetch_start, .obj_index, .render_row,
        .oam_addr, .oam_data, .attr, .attr_valid, .covered
    );

    obj_sequencer u_sequencer (
        .clock, .reset, .line_start, .fetch_start, .obj_index,
        .attr_valid, .covered, .width(attr.width), .col_offset, .req_valid
    );

    obj_pixel_addr u_pixel_addr (
        .attr, .render_row, .col_offset, .mosaic_reg, .obj_1d_map,
        .req_valid, .vram_addr, .req, .req_in_line
    );

    // vram_data for this request shows up one cycle after its address.
    always_ff @(posedge clock, posedge reset) begin
        if (reset) begin
            req_live_q <= 1'b0;
        end else begin
            req_live_q <= req_in_line;
        end
    end

    always_ff @(posedge clock) begin
        req_q <= req;
    end

    obj_pixel_unpack u_pixel_unpack (
        .req(req_q), .req_live(req_live_q), .vram_data, .pixel, .write
    );

    obj_line_buffer u_line_buffer (
        .clock, .reset, .line_start, .write, .wcol(req_q.column),
        .wpixel(pixel), .rcol(hcount), .rpixel(obj_packet)
    );

endmodule

`default_nettype wire

//--- src/obj_line_buffer.sv
`timescale 1ns/1ps
`default_nettype none

module obj_line_buffer import obj_pkg::*; (
    input  logic       clock,
    input  logic       reset,
    input  logic       line_start,
    input  logic       write,
    input  logic [7:0] wcol,
    input  obj_pixel_t wpixel,
    input  logic [7:0] rcol,
    output obj_pixel_t rpixel
);

    obj_pixel_t            mem [2][LINE_WIDTH];
    logic [LINE_WIDTH-1:0] present [2];
    logic                  sel;   // front bank, read by the display.
    logic                  back;
    logic                  write_hit;

    assign back      = ~sel;
    assign write_hit = write && !present[back][wcol];  // lower OAM index got here first.

    always_ff @(posedge clock, posedge reset) begin
        if (reset) begin
            sel        <= 1'b0;
            present[0] <= '0;
            present[1] <= '0;
        end else begin
            if (write_hit) present[back][wcol] <= 1'b1;
            if (line_start) begin
                sel          <= ~sel;
                present[sel] <= '0;   // the old front becomes the new back.
            end
        end
    end

    always_ff @(posedge clock) begin
        if (write_hit) mem[back][wcol] <= wpixel;
    end

    always_ff @(posedge clock, posedge reset) begin
        if (reset) begin
            rpixel <= '0;
        end else if (rcol < 8'(LINE_WIDTH) && present[sel][rcol]) begin
            rpixel <= mem[sel][rcol];
        end else begin
            rpixel <= '0;
        end
    end

    a_write_on_line: assert property (@(posedge clock) disable iff (reset)
        write |-> wcol < 8'(LINE_WIDTH));

endmodule

`default_nettype wire

//--- src/obj_pixel_unpack.sv
`timescale 1ns/1ps
`default_nettype none

module obj_pixel_unpack import obj_pkg::*; (
    input  obj_req_t    req,
    input  logic        req_live,
    input  logic [15:0] vram_data,
    output obj_pixel_t  pixel,
    output logic        write
);

    logic [3:0] nibble;
    logic [7:0] byte_sel;
    logic [7:0] index;
    logic       opaque;

    // the leftmost pixel sits in the lowest bits of the halfword.
    assign nibble   = vram_data[{req.x_low, 2'b00} +: 4];
    assign byte_sel = req.x_low[0] ? vram_data[15:8] : vram_data[7:0];

    assign index  = req.bpp8 ? byte_sel : {req.palette, nibble};
    assign opaque = req.bpp8 ? (byte_sel != 8'd0) : (nibble != 4'd0);  // index 0 is see-through.
    assign write  = req_live && opaque;

    always_comb begin
        pixel.present = write;
        pixel.prio    = req.prio;
        pixel.semi    = req.semi;
        pixel.bpp8    = req.bpp8;
        pixel.index   = index;
    end

endmodule

`default_nettype wire

//--- src/obj_pixel_addr.sv
`timescale 1ns/1ps
`default_nettype none

module obj_pixel_addr import obj_pkg::*; (
    input  obj_attr_t              attr,
    input  logic [7:0]             render_row,
    input  logic [6:0]             col_offset,
    input  logic [15:0]            mosaic_reg,
    input  logic                   obj_1d_map,
    input  logic                   req_valid,
    output logic [VRAM_ADDR_W-1:0] vram_addr,
    output obj_req_t               req,
    output logic                   req_in_line
);

    logic [7:0]             row_in;
    logic [6:0]             mos_w;
    logic [6:0]             mos_h;
    logic [6:0]             col_m;
    logic [6:0]             row_m;
    logic [6:0]             x_obj;
    logic [6:0]             y_obj;
    logic [9:0]             tiles_per_row;
    logic [9:0]             row_stride;
    logic [9:0]             col_step;
    logic [9:0]             tile_num;
    logic [4:0]             hw_in_tile;
    logic [VRAM_ADDR_W-1:0] addr;
    logic [8:0]             screen_col;

    assign row_in = render_row - attr.y;  // below height for any covered object.
    assign mos_w  = {3'b000, mosaic_reg[11:8]} + 7'd1;
    assign mos_h  = {3'b000, mosaic_reg[15:12]} + 7'd1;

    assign col_m = attr.mosaic ? col_offset - (col_offset % mos_w) : col_offset;
    assign row_m = attr.mosaic ? row_in[6:0] - (row_in[6:0] % mos_h) : row_in[6:0];
    assign x_obj = attr.hflip ? attr.width - 7'd1 - col_m : col_m;
    assign y_obj = attr.vflip ? attr.height - 7'd1 - row_m : row_m;

    // tile numbers count 32-byte units, so an 8bpp tile takes two of them.
    assign tiles_per_row = attr.bpp8 ? {5'b0, attr.width[6:3], 1'b0} : {6'b0, attr.width[6:3]};
    assign row_stride    = obj_1d_map ? tiles_per_row : 10'd32;
    assign col_step      = attr.bpp8 ? {6'b0, x_obj[5:3], 1'b0} : {7'b0, x_obj[5:3]};
    assign tile_num      = attr.tile + row_stride * 10'(y_obj[5:3]) + col_step;

    // 4bpp rows are two halfwords, 8bpp rows four.
    assign hw_in_tile = attr.bpp8 ? {y_obj[2:0], x_obj[2:1]} : {1'b0, y_obj[2:0], x_obj[2]};
    assign addr       = {tile_num, 4'b0000} + {9'b0, hw_in_tile};
    assign vram_addr  = req_valid ? addr : '0;

    assign screen_col  = attr.x + {2'b00, col_offset};
    assign req_in_line = req_valid && (screen_col < 9'(LINE_WIDTH));

    always_comb begin
        req.column  = screen_col[7:0];
        req.x_low   = x_obj[1:0];
        req.bpp8    = attr.bpp8;
        req.palette = attr.palette;
        req.prio    = attr.prio;
        req.semi    = (attr.mode == MODE_SEMI);
    end

endmodule

`default_nettype wire

//--- src/obj_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

module obj_sequencer import obj_pkg::*; (
    input  logic       clock,
    input  logic       reset,
    input  logic       line_start,
    output logic       fetch_start,
    output logic [6:0] obj_index,
    input  logic       attr_valid,
    input  logic       covered,
    input  logic [6:0] width,
    output logic [6:0] col_offset,
    output logic       req_valid
);

    obj_state_e state;
    logic       fetch_busy;   // a fetch is out and its attr_valid has not come back yet.
    logic       last_obj;
    logic       last_col;

    assign last_obj = (obj_index == 7'(NUM_OBJECTS - 1));
    assign last_col = (col_offset == width - 7'd1);

    // after an abandoned pass the stale attr_valid drains before the next fetch.
    assign fetch_start = (state == ST_FETCH) && !fetch_busy;
    assign req_valid   = (state == ST_DRAW) && !line_start;

    always_ff @(posedge clock, posedge reset) begin
        if (reset) begin
            fetch_busy <= 1'b0;
        end else if (fetch_start) begin
            fetch_busy <= 1'b1;
        end else if (attr_valid) begin
            fetch_busy <= 1'b0;
        end
    end

    always_ff @(posedge clock, posedge reset) begin
        if (reset) begin
            state      <= ST_IDLE;
            obj_index  <= '0;
            col_offset <= '0;
        end else if (line_start) begin
            state      <= ST_FETCH;
            obj_index  <= '0;
            col_offset <= '0;
        end else begin
            case (state)
                ST_FETCH: begin
                    if (fetch_start) state <= ST_WAIT_ATTR;
                end
                ST_WAIT_ATTR: begin
                    if (attr_valid) begin
                        if (covered) begin
                            state      <= ST_DRAW;
                            col_offset <= '0;
                        end else if (last_obj) begin
                            state <= ST_IDLE;
                        end else begin
                            obj_index <= obj_index + 7'd1;
                            state     <= ST_FETCH;
                        end
                    end
                end
                ST_DRAW: begin
                    if (last_col) begin
                        col_offset <= '0;
                        if (last_obj) begin
                            state <= ST_IDLE;
                        end else begin
                            obj_index <= obj_index + 7'd1;
                            state     <= ST_FETCH;
                        end
                    end else begin
                        col_offset <= col_offset + 7'd1;
                    end
                end
                default: ;  // idle until the next line.
            endcase
        end
    end

    a_req_in_object: assert property (@(posedge clock) disable iff (reset)
        req_valid |-> col_offset < width);

endmodule

`default_nettype wire

//--- src/obj_attr_fetch.sv
`timescale 1ns/1ps
`default_nettype none

module obj_attr_fetch import obj_pkg::*; (
    input  logic                  clock,
    input  logic                  reset,
    input  logic                  fetch_start,
    input  logic [6:0]            obj_index,
    input  logic [7:0]            render_row,
    output logic [OAM_ADDR_W-1:0] oam_addr,
    input  logic [31:0]           oam_data,
    output obj_attr_t             attr,
    output logic                  attr_valid,
    output logic                  covered
);

    logic [1:0]  stage;   // bit 0 waits on word 2n, bit 1 on word 2n+1.
    logic [6:0]  index_q;
    logic [31:0] word0_q;
    logic [15:0] attr2_q;
    logic [15:0] attr0;
    logic [15:0] attr1;
    obj_size_t   dims;
    obj_mode_e   raw_mode;
    logic [7:0]  row_in_obj;

    always_ff @(posedge clock, posedge reset) begin
        if (reset) begin
            stage      <= '0;
            attr_valid <= 1'b0;
        end else begin
            stage      <= {stage[0], fetch_start};
            attr_valid <= stage[1];
        end
    end

    always_ff @(posedge clock) begin
        if (fetch_start) index_q <= obj_index;
        if (stage[0]) word0_q <= oam_data;
        if (stage[1]) attr2_q <= oam_data[15:0];
    end

    always_comb begin
        if (fetch_start) begin
            oam_addr = {obj_index, 1'b0};
        end else if (stage[0]) begin
            oam_addr = {index_q, 1'b1};
        end else begin
            oam_addr = '0;
        end
    end

    assign attr0    = word0_q[15:0];
    assign attr1    = word0_q[31:16];
    assign dims     = obj_dims(attr0[15:14], attr1[15:14]);
    assign raw_mode = obj_mode_e'(attr0[11:10]);

    always_comb begin
        attr.y        = attr0[7:0];
        attr.x        = attr1[8:0];
        attr.mosaic   = attr0[12];
        attr.bpp8     = attr0[13];
        attr.hflip    = attr1[12];
        attr.vflip    = attr1[13];
        attr.dbl_size = attr0[9];
        attr.width    = dims.width;
        attr.height   = dims.height;
        attr.tile     = attr2_q[9:0];
        attr.prio     = attr2_q[11:10];
        attr.palette  = attr2_q[15:12];
        // no affine support, so double-size objects are dropped with the window ones.
        if (attr0[9] || raw_mode == MODE_WINDOW) begin
            attr.mode = MODE_HIDDEN;
        end else begin
            attr.mode = raw_mode;
        end
    end

    assign row_in_obj = render_row - attr.y;  // wraps so objects near y 255 reach row 0.
    assign covered    = (attr.mode != MODE_HIDDEN) && (row_in_obj < {1'b0, attr.height});

    a_fetch_no_overlap: assert property (@(posedge clock) disable iff (reset)
        fetch_start |-> (stage == 2'b00));

endmodule

`default_nettype wire

//--- src/obj_pkg.sv
`default_nettype none

package obj_pkg;

    localparam int LINE_WIDTH  = 240;
    localparam int NUM_OBJECTS = 128;
    localparam int OAM_ADDR_W  = 8;
    localparam int VRAM_ADDR_W = 14;

    // attribute 0 bits 11:10.
    typedef enum logic [1:0] {
        MODE_NORMAL = 2'd0,
        MODE_SEMI   = 2'd1,
        MODE_WINDOW = 2'd2,
        MODE_HIDDEN = 2'd3
    } obj_mode_e;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_FETCH,
        ST_WAIT_ATTR,
        ST_DRAW
    } obj_state_e;

    typedef struct packed {
        logic [7:0] y;
        logic [8:0] x;
        obj_mode_e  mode;
        logic       mosaic;
        logic       bpp8;
        logic       hflip;
        logic       vflip;
        logic       dbl_size;
        logic [6:0] width;
        logic [6:0] height;
        logic [9:0] tile;
        logic [1:0] prio;
        logic [3:0] palette;
    } obj_attr_t;

    typedef struct packed {
        logic [7:0] column;
        logic [1:0] x_low;   // in-object x bits 1:0, selects nibble or byte.
        logic       bpp8;
        logic [3:0] palette;
        logic [1:0] prio;
        logic       semi;
    } obj_req_t;

    typedef struct packed {
        logic       present;
        logic [1:0] prio;
        logic       semi;
        logic       bpp8;
        logic [7:0] index;
    } obj_pixel_t;

    typedef struct packed {
        logic [6:0] width;
        logic [6:0] height;
    } obj_size_t;

    // shape 0 is square, 1 is wide, 2 is tall. Shape 3 is not a legal shape.
    function automatic obj_size_t obj_dims(input logic [1:0] shape, input logic [1:0] size);
        obj_size_t d;
        d = '{width: 7'd8, height: 7'd8};
        case (shape)
            2'd0: begin
                d.width  = 7'd8 << size;
                d.height = 7'd8 << size;
            end
            2'd1, 2'd2: begin
                case (size)
                    2'd0: d = '{width: 7'd16, height: 7'd8};
                    2'd1: d = '{width: 7'd32, height: 7'd8};
                    2'd2: d = '{width: 7'd32, height: 7'd16};
                    default: d = '{width: 7'd64, height: 7'd32};
                endcase
                if (shape == 2'd2) begin
                    d = '{width: d.height, height: d.width};
                end
            end
            default: ;
        endcase
        return d;
    endfunction

endpackage

`default_nettype wire
